//--- hw/video_pkg.sv
package video_pkg;

	// active raster only, no blanking.
	localparam int H_ACTIVE = 80;
	localparam int V_ACTIVE = 60;

	localparam int COL_W = 10;
	localparam int ROW_W = 9;

	// buffer depth and starting credit count.
	localparam int CREDITS = 8;
	localparam int CREDIT_W = $clog2(CREDITS + 1);
	localparam int PTR_W = $clog2(CREDITS);

endpackage

//--- hw/sprite_pkg.sv
package sprite_pkg;

	// square window, one rom word per sprite row.
	localparam int SPRITE_SIZE = 20;
	localparam int OFF_W = $clog2(SPRITE_SIZE);

	// animation.
	localparam int ANIM1_FRAMES = 4;
	localparam int ANIM2_FRAMES = 3;
	localparam int ANIM_W = 2;
	localparam int FRAME_HOLD = 2;
	localparam int HOLD_W = $clog2(FRAME_HOLD + 1);

	// four frames of twenty rows.
	localparam int ROM_DEPTH = 80;
	localparam int ROM_AW = 7;

	// ink codes.
	localparam int INK_W = 2;
	localparam logic [INK_W-1:0] INK_NONE = 2'd0;
	localparam logic [INK_W-1:0] INK_S1 = 2'd1;
	localparam logic [INK_W-1:0] INK_S2 = 2'd2;

	// 8-bit colors, white and yellow on black.
	localparam logic [7:0] COLOR_S1 = 8'hFF;
	localparam logic [7:0] COLOR_S2 = 8'hFC;
	localparam logic [7:0] COLOR_BG = 8'h00;

endpackage

//--- hw/pixel_if.sv
`timescale 1ns/1ps

// coordinates from the scan generator.
interface scan_if;
	logic valid;
	logic [video_pkg::ROW_W-1:0] row;
	logic [video_pkg::COL_W-1:0] col;
	logic frame_start;

	modport source (output valid, row, col, frame_start);
	modport sink (input valid, row, col, frame_start);
endinterface

// finished pixels into the buffer, credits back to the scan.
interface pixel_credit_if;
	logic valid;
	logic [video_pkg::ROW_W-1:0] row;
	logic [video_pkg::COL_W-1:0] col;
	logic [sprite_pkg::INK_W-1:0] ink;
	logic frame_start;
	logic credit;

	modport source (output valid, row, col, ink, frame_start);
	modport buffer (input valid, row, col, ink, frame_start, output credit);
	modport watch (input credit);
endinterface

// buffer head to the output stage.
interface pixel_drain_if;
	logic valid;
	logic pop;
	logic [video_pkg::ROW_W-1:0] row;
	logic [video_pkg::COL_W-1:0] col;
	logic [sprite_pkg::INK_W-1:0] ink;
	logic frame_start;

	modport buffer (output valid, row, col, ink, frame_start, input pop);
	modport sink (input valid, row, col, ink, frame_start, output pop);
endinterface

//--- hw/raster_scan.sv
`timescale 1ns/1ps

module raster_scan (
	input logic clk,
	input logic reset,
	scan_if.source scan,
	pixel_credit_if.watch credit_in
);
	import video_pkg::*;

	logic [CREDIT_W-1:0] credit_cnt;
	logic [ROW_W-1:0] row_cnt;
	logic [COL_W-1:0] col_cnt;
	logic issue;
	logic last_col;
	logic last_row;

	assign issue = (credit_cnt != '0);
	assign last_col = (col_cnt == COL_W'(H_ACTIVE - 1));
	assign last_row = (row_cnt == ROW_W'(V_ACTIVE - 1));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			credit_cnt <= CREDIT_W'(CREDITS);
			row_cnt <= '0;
			col_cnt <= '0;
			scan.valid <= 1'b0;
		end
		else
		begin
			scan.valid <= issue;
			// one spent per issue, one back per pop.
			case ({issue, credit_in.credit})
				2'b10: credit_cnt <= credit_cnt - 1'b1;
				2'b01: credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
			if (issue)
			begin
				col_cnt <= last_col ? '0 : col_cnt + 1'b1;
				if (last_col)
					row_cnt <= last_row ? '0 : row_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			scan.row <= row_cnt;
			scan.col <= col_cnt;
			scan.frame_start <= (row_cnt == '0) && (col_cnt == '0);
		end
	end

endmodule

//--- hw/sparkle_rom.sv
`timescale 1ns/1ps

module sparkle_rom (
	input logic clk,
	input logic [sprite_pkg::ROM_AW-1:0] addr,
	output logic [sprite_pkg::SPRITE_SIZE-1:0] data
);
	import sprite_pkg::*;

	logic [SPRITE_SIZE-1:0] mem [ROM_DEPTH];

	initial
	begin
		$readmemh("hw/sparkle_rom.hex", mem);
	end

	always_ff @(posedge clk)
	begin
		data <= mem[addr];
	end

endmodule

//--- hw/sparkle_anim.sv
`timescale 1ns/1ps

module sparkle_anim (
	input logic clk,
	input logic reset,
	input logic [video_pkg::ROW_W-1:0] sprite1_row,
	input logic [video_pkg::ROW_W-1:0] sprite2_row,
	input logic [video_pkg::COL_W-1:0] sprite1_col,
	input logic [video_pkg::COL_W-1:0] sprite2_col,
	scan_if.sink scan,
	pixel_credit_if.source pix
);
	import video_pkg::*;
	import sprite_pkg::*;

	logic [ROW_W-1:0] pos1_row_q;
	logic [ROW_W-1:0] pos2_row_q;
	logic [COL_W-1:0] pos1_col_q;
	logic [COL_W-1:0] pos2_col_q;
	logic frame_seen;
	logic [HOLD_W-1:0] hold_cnt;
	logic [HOLD_W-1:0] hold_nxt;
	logic [ANIM_W-1:0] anim1_q;
	logic [ANIM_W-1:0] anim2_q;
	logic [ANIM_W-1:0] anim1_nxt;
	logic [ANIM_W-1:0] anim2_nxt;
	logic fs_now;
	logic [ROW_W-1:0] pos1_row;
	logic [ROW_W-1:0] pos2_row;
	logic [COL_W-1:0] pos1_col;
	logic [COL_W-1:0] pos2_col;
	logic [ANIM_W-1:0] anim1;
	logic [ANIM_W-1:0] anim2;
	logic [ROW_W-1:0] r1_off;
	logic [ROW_W-1:0] r2_off;
	logic [COL_W-1:0] c1_off;
	logic [COL_W-1:0] c2_off;
	logic in1;
	logic in2;
	logic [INK_W-1:0] hit_d;
	logic [ROM_AW-1:0] addr_d;
	logic [OFF_W-1:0] coff_d;
	logic st1_valid;
	logic [ROW_W-1:0] st1_row;
	logic [COL_W-1:0] st1_col;
	logic st1_fs;
	logic [INK_W-1:0] st1_hit;
	logic [ROM_AW-1:0] st1_addr;
	logic [OFF_W-1:0] st1_coff;
	logic st2_valid;
	logic [ROW_W-1:0] st2_row;
	logic [COL_W-1:0] st2_col;
	logic st2_fs;
	logic [INK_W-1:0] st2_hit;
	logic [OFF_W-1:0] st2_coff;
	logic [SPRITE_SIZE-1:0] rom_data;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// per-frame state
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign fs_now = scan.valid & scan.frame_start;

	// first frame_start is frame 0, no advance.
	always_comb
	begin
		hold_nxt = hold_cnt;
		anim1_nxt = anim1_q;
		anim2_nxt = anim2_q;
		if (frame_seen)
		begin
			if (hold_cnt == HOLD_W'(FRAME_HOLD - 1))
			begin
				hold_nxt = '0;
				anim1_nxt = (anim1_q == ANIM_W'(ANIM1_FRAMES - 1)) ? '0 : anim1_q + 1'b1;
				anim2_nxt = (anim2_q == ANIM_W'(ANIM2_FRAMES - 1)) ? '0 : anim2_q + 1'b1;
			end
			else
				hold_nxt = hold_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			frame_seen <= 1'b0;
			hold_cnt <= '0;
			anim1_q <= '0;
			anim2_q <= '0;
		end
		else if (fs_now)
		begin
			frame_seen <= 1'b1;
			hold_cnt <= hold_nxt;
			anim1_q <= anim1_nxt;
			anim2_q <= anim2_nxt;
		end
	end

	always_ff @(posedge clk)
	begin
		if (fs_now)
		begin
			pos1_row_q <= sprite1_row;
			pos1_col_q <= sprite1_col;
			pos2_row_q <= sprite2_row;
			pos2_col_q <= sprite2_col;
		end
	end

	// the frame_start pixel already sees the new frame.
	assign pos1_row = fs_now ? sprite1_row : pos1_row_q;
	assign pos1_col = fs_now ? sprite1_col : pos1_col_q;
	assign pos2_row = fs_now ? sprite2_row : pos2_row_q;
	assign pos2_col = fs_now ? sprite2_col : pos2_col_q;
	assign anim1 = fs_now ? anim1_nxt : anim1_q;
	assign anim2 = fs_now ? anim2_nxt : anim2_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 1, window test and rom address
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign r1_off = scan.row - pos1_row;
	assign c1_off = scan.col - pos1_col;
	assign r2_off = scan.row - pos2_row;
	assign c2_off = scan.col - pos2_col;

	assign in1 = (scan.row >= pos1_row) && (r1_off < ROW_W'(SPRITE_SIZE))
		&& (scan.col >= pos1_col) && (c1_off < COL_W'(SPRITE_SIZE));
	assign in2 = (scan.row >= pos2_row) && (r2_off < ROW_W'(SPRITE_SIZE))
		&& (scan.col >= pos2_col) && (c2_off < COL_W'(SPRITE_SIZE));

	// sprite 1 on top.
	always_comb
	begin
		hit_d = INK_NONE;
		addr_d = '0;
		coff_d = '0;
		if (in1)
		begin
			hit_d = INK_S1;
			addr_d = ROM_AW'(anim1) * ROM_AW'(SPRITE_SIZE) + ROM_AW'(r1_off);
			coff_d = OFF_W'(c1_off);
		end
		else if (in2)
		begin
			hit_d = INK_S2;
			addr_d = ROM_AW'(anim2) * ROM_AW'(SPRITE_SIZE) + ROM_AW'(r2_off);
			coff_d = OFF_W'(c2_off);
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			st1_valid <= 1'b0;
			st2_valid <= 1'b0;
		end
		else
		begin
			st1_valid <= scan.valid;
			st2_valid <= st1_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		st1_row <= scan.row;
		st1_col <= scan.col;
		st1_fs <= scan.frame_start;
		st1_hit <= hit_d;
		st1_addr <= addr_d;
		st1_coff <= coff_d;
		st2_row <= st1_row;
		st2_col <= st1_col;
		st2_fs <= st1_fs;
		st2_hit <= st1_hit;
		st2_coff <= st1_coff;
	end

	sparkle_rom u_rom (
		.clk (clk),
		.addr (st1_addr),
		.data (rom_data)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 2, bit select
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// msb is the leftmost column.
	assign pix.ink = ((st2_hit != INK_NONE) && rom_data[OFF_W'(SPRITE_SIZE - 1) - st2_coff])
		? st2_hit : INK_NONE;
	assign pix.valid = st2_valid;
	assign pix.row = st2_row;
	assign pix.col = st2_col;
	assign pix.frame_start = st2_fs;

endmodule

//--- hw/pixel_fifo.sv
`timescale 1ns/1ps

module pixel_fifo (
	input logic clk,
	input logic reset,
	pixel_credit_if.buffer wr,
	pixel_drain_if.buffer rd
);
	import video_pkg::*;
	import sprite_pkg::*;

	logic [ROW_W-1:0] mem_row [CREDITS];
	logic [COL_W-1:0] mem_col [CREDITS];
	logic [INK_W-1:0] mem_ink [CREDITS];
	logic mem_fs [CREDITS];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CREDIT_W-1:0] count;
	logic do_push;
	logic do_pop;

	// space is guaranteed by the credit loop.
	assign do_push = wr.valid;
	assign do_pop = rd.pop & rd.valid;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			wr.credit <= 1'b0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			wr.credit <= do_pop;
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_push)
		begin
			mem_row[wr_ptr] <= wr.row;
			mem_col[wr_ptr] <= wr.col;
			mem_ink[wr_ptr] <= wr.ink;
			mem_fs[wr_ptr] <= wr.frame_start;
		end
	end

	// head entry.
	assign rd.valid = (count != '0);
	assign rd.row = mem_row[rd_ptr];
	assign rd.col = mem_col[rd_ptr];
	assign rd.ink = mem_ink[rd_ptr];
	assign rd.frame_start = mem_fs[rd_ptr];

endmodule

//--- hw/pixel_out.sv
`timescale 1ns/1ps

module pixel_out (
	input logic clk,
	input logic reset,
	pixel_drain_if.sink rd,
	input logic out_ready,
	output logic pixel_valid,
	output logic pixel_frame_start,
	output logic [video_pkg::ROW_W-1:0] pixel_row,
	output logic [video_pkg::COL_W-1:0] pixel_col,
	output logic [7:0] pixel_color
);
	import sprite_pkg::*;

	logic load;
	logic [7:0] ink_color;

	// refill when empty or being taken.
	assign load = rd.valid & (~pixel_valid | out_ready);
	assign rd.pop = load;

	always_comb
	begin
		case (rd.ink)
			INK_S1: ink_color = COLOR_S1;
			INK_S2: ink_color = COLOR_S2;
			default: ink_color = COLOR_BG;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			pixel_valid <= 1'b0;
		else if (load)
			pixel_valid <= 1'b1;
		else if (out_ready)
			pixel_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			pixel_row <= rd.row;
			pixel_col <= rd.col;
			pixel_color <= ink_color;
			pixel_frame_start <= rd.frame_start;
		end
	end

endmodule

//--- hw/sparkle_top.sv
`timescale 1ns/1ps

module sparkle_top (
	input logic clk,
	input logic reset,
	input logic [video_pkg::ROW_W-1:0] sprite1_row,
	input logic [video_pkg::COL_W-1:0] sprite1_col,
	input logic [video_pkg::ROW_W-1:0] sprite2_row,
	input logic [video_pkg::COL_W-1:0] sprite2_col,
	input logic out_ready,
	output logic pixel_valid,
	output logic [video_pkg::ROW_W-1:0] pixel_row,
	output logic [video_pkg::COL_W-1:0] pixel_col,
	output logic [7:0] pixel_color,
	output logic pixel_frame_start
);

	scan_if scan ();
	pixel_credit_if pix ();
	pixel_drain_if drain ();

	// scan -> anim -> buffer -> output register.
	raster_scan u_scan (
		.clk (clk),
		.reset (reset),
		.scan (scan),
		.credit_in (pix)
	);

	sparkle_anim u_anim (
		.clk (clk),
		.reset (reset),
		.sprite1_row (sprite1_row),
		.sprite2_row (sprite2_row),
		.sprite1_col (sprite1_col),
		.sprite2_col (sprite2_col),
		.scan (scan),
		.pix (pix)
	);

	pixel_fifo u_fifo (
		.clk (clk),
		.reset (reset),
		.wr (pix),
		.rd (drain)
	);

	pixel_out u_out (
		.clk (clk),
		.reset (reset),
		.rd (drain),
		.out_ready (out_ready),
		.pixel_valid (pixel_valid),
		.pixel_frame_start (pixel_frame_start),
		.pixel_row (pixel_row),
		.pixel_col (pixel_col),
		.pixel_color (pixel_color)
	);

endmodule

//--- tb/sparkle_chk.sv
`timescale 1ns/1ps

module sparkle_chk (
	input logic clk,
	input logic reset,
	input logic out_ready,
	input logic pixel_valid,
	input logic [video_pkg::ROW_W-1:0] pixel_row,
	input logic [video_pkg::COL_W-1:0] pixel_col,
	input logic [7:0] pixel_color,
	input logic pixel_frame_start,
	input logic push,
	input logic [video_pkg::CREDIT_W-1:0] fifo_count,
	input logic [video_pkg::CREDIT_W-1:0] credit_cnt
);
	import video_pkg::*;

	int fail_count = 0;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// output register under stall
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	hold_stable: assert property (@(posedge clk) disable iff (reset)
		(pixel_valid && !out_ready) |=> (pixel_valid && $stable(pixel_row)
		&& $stable(pixel_col) && $stable(pixel_color) && $stable(pixel_frame_start)))
	else
	begin
		fail_count++;
		$error("stalled output pixel changed before it was accepted");
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// credit loop
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	no_overflow: assert property (@(posedge clk) disable iff (reset)
		push |-> (fifo_count < CREDIT_W'(CREDITS)))
	else
	begin
		fail_count++;
		$error("pixel pushed into a full buffer");
	end

	credit_bound: assert property (@(posedge clk) disable iff (reset)
		credit_cnt <= CREDIT_W'(CREDITS))
	else
	begin
		fail_count++;
		$error("credit count above the buffer depth");
	end

	// synchronous reset, so checked one edge later.
	reset_quiet: assert property (@(posedge clk) reset |=> !pixel_valid)
	else
	begin
		fail_count++;
		$error("pixel_valid high during reset");
	end

endmodule

//--- tb/sparkle_tb.sv
`timescale 1ns/1ps

module sparkle_tb;
	import video_pkg::*;
	import sprite_pkg::*;

	localparam int NUM_FRAMES = 9;
	localparam int FRAME_LIMIT = 40000;
	localparam int MID_ROW = 30;

	logic clk = 1'b0;
	logic reset;
	logic [ROW_W-1:0] sprite1_row;
	logic [COL_W-1:0] sprite1_col;
	logic [ROW_W-1:0] sprite2_row;
	logic [COL_W-1:0] sprite2_col;
	logic out_ready;
	logic pixel_valid;
	logic [ROW_W-1:0] pixel_row;
	logic [COL_W-1:0] pixel_col;
	logic [7:0] pixel_color;
	logic pixel_frame_start;

	logic [SPRITE_SIZE-1:0] rom_model [ROM_DEPTH];
	logic [31:0] rnd_state = 32'd5185;
	logic rst_d = 1'b0;
	logic rst_dd = 1'b0;
	int exp_row = 0;
	int exp_col = 0;
	int frame_idx = -1;
	int p1r;
	int p1c;
	int p2r;
	int p2c;
	int mismatch_errors = 0;
	int other_errors = 0;
	int assert_errors = 0;
	bit ok;
	int f;

	sparkle_top uut (
		.clk (clk),
		.reset (reset),
		.sprite1_row (sprite1_row),
		.sprite1_col (sprite1_col),
		.sprite2_row (sprite2_row),
		.sprite2_col (sprite2_col),
		.out_ready (out_ready),
		.pixel_valid (pixel_valid),
		.pixel_row (pixel_row),
		.pixel_col (pixel_col),
		.pixel_color (pixel_color),
		.pixel_frame_start (pixel_frame_start)
	);

	bind sparkle_top sparkle_chk u_chk (
		.clk (clk),
		.reset (reset),
		.out_ready (out_ready),
		.pixel_valid (pixel_valid),
		.pixel_row (pixel_row),
		.pixel_col (pixel_col),
		.pixel_color (pixel_color),
		.pixel_frame_start (pixel_frame_start),
		.push (pix.valid),
		.fifo_count (u_fifo.count),
		.credit_cnt (u_scan.credit_cnt)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// sprite 1 over sprite 2 with each frame held for FRAME_HOLD frames.
	function automatic logic [7:0] expected_color(input int row, input int col);
		int a1;
		int a2;
		logic [SPRITE_SIZE-1:0] w;
		a1 = (frame_idx / FRAME_HOLD) % ANIM1_FRAMES;
		a2 = (frame_idx / FRAME_HOLD) % ANIM2_FRAMES;
		if (row >= p1r && row < p1r + SPRITE_SIZE && col >= p1c && col < p1c + SPRITE_SIZE)
		begin
			w = rom_model[a1 * SPRITE_SIZE + row - p1r];
			return w[SPRITE_SIZE - 1 - (col - p1c)] ? COLOR_S1 : COLOR_BG;
		end
		if (row >= p2r && row < p2r + SPRITE_SIZE && col >= p2c && col < p2c + SPRITE_SIZE)
		begin
			w = rom_model[a2 * SPRITE_SIZE + row - p2r];
			return w[SPRITE_SIZE - 1 - (col - p2c)] ? COLOR_S2 : COLOR_BG;
		end
		return COLOR_BG;
	endfunction

	task automatic report_mismatch(input string name, input int expected, input int actual);
		mismatch_errors++;
		$display("MISMATCH at %0t: %s expected %0d got %0d", $time, name, expected, actual);
	endtask

	task automatic check_pixel();
		logic exp_fs;
		logic [7:0] exp_color;
		exp_fs = (exp_row == 0) && (exp_col == 0);
		if (exp_fs)
		begin
			// positions as they stood at frame_start.
			frame_idx++;
			p1r = sprite1_row;
			p1c = sprite1_col;
			p2r = sprite2_row;
			p2c = sprite2_col;
		end
		exp_color = expected_color(exp_row, exp_col);
		assert (pixel_row == exp_row)
		else report_mismatch("pixel_row", exp_row, pixel_row);
		assert (pixel_col == exp_col)
		else report_mismatch("pixel_col", exp_col, pixel_col);
		assert (pixel_frame_start == exp_fs)
		else report_mismatch("pixel_frame_start", exp_fs, pixel_frame_start);
		assert (pixel_color == exp_color)
		else report_mismatch("pixel_color", exp_color, pixel_color);
		if (exp_col == H_ACTIVE - 1)
		begin
			exp_col = 0;
			exp_row = (exp_row == V_ACTIVE - 1) ? 0 : exp_row + 1;
		end
		else
			exp_col++;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// sprite 2 always lands inside the window of sprite 1.
	task automatic place_sprites(input int k);
		int r1;
		int c1;
		r1 = (7 * k + 5) % 45;
		c1 = (13 * k + 3) % 65;
		sprite1_row = ROW_W'(r1);
		sprite1_col = COL_W'(c1);
		sprite2_row = ROW_W'(r1 + 6 + k % 5);
		sprite2_col = COL_W'(c1 + 4 + 2 * (k % 4));
	endtask

	task automatic wait_frame_row(input int frame, input int row, output bit done);
		int cycles;
		cycles = 0;
		done = 1'b1;
		while (!(frame_idx > frame || (frame_idx == frame && exp_row >= row)))
		begin
			@(negedge clk);
			cycles++;
			if (cycles > FRAME_LIMIT)
			begin
				done = 1'b0;
				break;
			end
		end
	endtask

	task automatic finish_run();
		int total;
		assert_errors = uut.u_chk.fail_count;
		total = mismatch_errors + other_errors + assert_errors;
		$display("errors: %0d mismatch, %0d other, %0d assertion",
			mismatch_errors, other_errors, assert_errors);
		if (total == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	endtask

	// random back-pressure.
	always @(negedge clk)
	begin
		rnd_state = xorshift32(rnd_state);
		out_ready <= rnd_state[0];
	end

	// covers every reset edge and the first edge after release.
	always @(posedge clk)
	begin
		if (rst_d || rst_dd)
		begin
			assert (pixel_valid === 1'b0)
			else
			begin
				mismatch_errors++;
				$display("MISMATCH at %0t: pixel_valid expected 0 got %b", $time, pixel_valid);
			end
		end
		if (!reset && pixel_valid && out_ready)
			check_pixel();
		rst_dd = rst_d;
		rst_d = reset;
	end

	initial
	begin
		reset = 1'b1;
		out_ready = 1'b0;
		place_sprites(0);
		$readmemh("hw/sparkle_rom.hex", rom_model);
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		ok = 1'b1;
		for (f = 0; f < NUM_FRAMES && ok; f++)
		begin
			wait_frame_row(f, MID_ROW, ok);
			// moved mid-frame and due from the next frame.
			if (ok)
				place_sprites(f + 1);
		end
		if (ok)
			wait_frame_row(NUM_FRAMES, 0, ok);
		if (!ok)
		begin
			other_errors++;
			$display("timeout: pixel stream stopped in frame %0d at row %0d", frame_idx, exp_row);
		end
		finish_run();
	end

endmodule

//--- src.f
hw/video_pkg.sv
hw/sprite_pkg.sv
hw/pixel_if.sv
hw/raster_scan.sv
hw/sparkle_rom.sv
hw/sparkle_anim.sv
hw/pixel_fifo.sv
hw/pixel_out.sv
hw/sparkle_top.sv
tb/sparkle_chk.sv
tb/sparkle_tb.sv

//--- hw/sparkle_rom.hex
// sparkle sprite rom. one 20-bit row per line, msb is the leftmost column.
// four animation frames of 20 rows each.
// frame 0
00000
00000
00000
00000
00000
00000
00600
00600
00600
03FC0
03FC0
00600
00600
00600
00000
00000
00000
00000
00000
00000
// frame 1
00000
00000
00000
00600
00600
04620
00600
00600
00600
1FFF8
1FFF8
00600
00600
00600
04620
00600
00600
00000
00000
00000
// frame 2
80601
40602
20604
10608
08610
04620
02640
01680
00F00
FFFFF
FFFFF
00F00
01680
02640
04620
08610
10608
20604
40602
80601
// frame 3
00000
00000
00000
00000
08010
04020
02040
01080
00900
00600
00600
00900
01080
02040
04020
08010
00000
00000
00000
00000
